//--- src.f
src/mldsa_params_pkg.sv
src/pwo_defines_pkg.sv
src/pwo_ctrl.sv
src/pwo_mod_mul.sv
src/pwo_lane.sv
src/pwo_datapath.sv
src/pwo_top.sv
test/pwo_top_assert.sv
test/pwo_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the pointwise engine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f src.f --top-module pwo_top_tb -o pwo_top_sim

./obj_dir/pwo_top_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

//--- test/pwo_top_tb.sv
// Testbench of the pointwise engine
// Clock, reset, memory models with one-cycle read latency
// LCG stimulus, reference model and result checks

module pwo_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mldsa_params_pkg::*;
    import pwo_defines_pkg::*;

    localparam int          NUM_WORDS = 64;
    localparam int          MEM_DEPTH = 2 ** MEM_ADDR_WIDTH;
    localparam int          TIMEOUT   = 2000;
    localparam logic [31:0] SEED      = 32'h8559ebb6;

    logic           clk = 1'b0;
    logic           reset_n;
    logic           zeroize_i;
    logic           enable_i;
    pwo_mode_t      mode_i;
    logic           accumulate_i;
    logic           sampler_valid_i;
    pwo_base_addr_t base_addr_i;
    mem_word_t      a_rd_data_i = '0;
    mem_word_t      b_rd_data_i = '0;
    mem_word_t      c_rd_data_i = '0;
    mem_req_t       a_rd_req_o;
    mem_req_t       b_rd_req_o;
    mem_req_t       c_rd_req_o;
    mem_req_t       wr_req_o;
    mem_word_t      wr_data_o;
    logic           busy_o;
    logic           done_o;

    // Memory models with writes landing in a separate result array
    mem_word_t   mem_a [MEM_DEPTH];
    mem_word_t   mem_b [MEM_DEPTH];
    mem_word_t   mem_c [MEM_DEPTH];
    mem_word_t   result [MEM_DEPTH];
    int          wr_count [MEM_DEPTH];
    mem_req_t    a_pend = '0;
    mem_req_t    b_pend = '0;
    mem_req_t    c_pend = '0;
    int          wr_total = 0;
    int          c_rd_total = 0;
    int          done_count = 0;
    int          cycle_cnt = 0;
    int          last_wr_cycle = 0;
    int          done_cycle = 0;
    mem_word_t   expected [NUM_WORDS];
    logic [31:0] rand_state;
    int          errors;
    int          timeouts;

    pwo_top #(.NUM_WORDS(NUM_WORDS)) u_pwo_top (.*);

    always #5 clk = ~clk;

    // ============================================================
    // Random numbers and reference model
    // ============================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = lcg_next(rand_state);
        return rand_state;
    endfunction

    // Mostly uniform below Q with the occasional edge value 0 or Q-1
    function automatic coeff_t rand_coeff();
        logic [31:0] r;
        r = next_rand();
        if (r[31:29] == 3'd0) begin
            return r[28] ? coeff_t'(MLDSA_Q - 1'b1) : '0;
        end
        return coeff_t'(r[31:8] % {1'b0, MLDSA_Q});
    endfunction

    function automatic mem_word_t rand_word();
        mem_word_t w;
        w = '0;
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            w[i*LANE_WIDTH +: COEFF_WIDTH] = rand_coeff();
        end
        return w;
    endfunction

    function automatic logic draw_valid(input logic gaps);
        logic [31:0] r;
        r = next_rand();
        return !gaps || (r[31:30] != 2'b00);
    endfunction

    function automatic mem_addr_t word_addr(input mem_addr_t base, input int k);
        return base + mem_addr_t'(k);
    endfunction

    function automatic mem_word_t model_word(input pwo_mode_t mode, input logic acc,
                                             input mem_word_t a, input mem_word_t b,
                                             input mem_word_t c);
        longint unsigned q;
        longint unsigned x;
        longint unsigned y;
        longint unsigned z;
        longint unsigned r;
        mem_word_t       w;
        q = 64'(MLDSA_Q);
        w = '0;
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            x = 64'(a[i*LANE_WIDTH +: COEFF_WIDTH]);
            y = 64'(b[i*LANE_WIDTH +: COEFF_WIDTH]);
            z = acc ? 64'(c[i*LANE_WIDTH +: COEFF_WIDTH]) : 64'd0;
            case (mode)
                PWO_PWA: r = (x + y) % q;
                PWO_PWS: r = (x + q - y) % q;
                default: r = (z + x * y) % q;
            endcase
            w[i*LANE_WIDTH +: COEFF_WIDTH] = coeff_t'(r);
        end
        return w;
    endfunction

    // ============================================================
    // Memory models and write monitor
    // ============================================================
    always @(posedge clk) begin
        cycle_cnt++;
        a_pend = a_rd_req_o;
        b_pend = b_rd_req_o;
        c_pend = c_rd_req_o;
        if (c_rd_req_o.rd_wr_en == RW_READ) begin
            c_rd_total++;
        end
        if (wr_req_o.rd_wr_en == RW_WRITE) begin
            result[wr_req_o.addr] = wr_data_o;
            wr_count[wr_req_o.addr]++;
            wr_total++;
            last_wr_cycle = cycle_cnt;
        end
        if (done_o) begin
            done_count++;
            done_cycle = cycle_cnt;
        end
    end

    // Read data shows up in the cycle after the request
    always @(negedge clk) begin
        if (a_pend.rd_wr_en == RW_READ) begin
            a_rd_data_i = mem_a[a_pend.addr];
        end
        if (b_pend.rd_wr_en == RW_READ) begin
            b_rd_data_i = mem_b[b_pend.addr];
        end
        if (c_pend.rd_wr_en == RW_READ) begin
            c_rd_data_i = mem_c[c_pend.addr];
        end
    end

    task automatic report_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    // One operation that zeroize may cut short after some writes
    task automatic run_op(input pwo_mode_t mode, input logic acc, input logic gaps,
                          input int zero_after);
        pwo_base_addr_t base;
        mem_addr_t      addr;
        int             cycles;
        int             total_before;
        int             done_before;
        int             c_rd_before;
        int             c_rd_expected;
        int             count_before [NUM_WORDS];
        if (timeouts > 0) begin
            return;
        end
        base.base_a = mem_addr_t'(next_rand() >> 17);
        base.base_b = mem_addr_t'(next_rand() >> 17);
        base.base_c = mem_addr_t'(next_rand() >> 17);
        for (int k = 0; k < NUM_WORDS; k++) begin
            mem_a[word_addr(base.base_a, k)] = rand_word();
            mem_b[word_addr(base.base_b, k)] = rand_word();
            mem_c[word_addr(base.base_c, k)] = rand_word();
            expected[k] = model_word(mode, acc, mem_a[word_addr(base.base_a, k)],
                                     mem_b[word_addr(base.base_b, k)],
                                     mem_c[word_addr(base.base_c, k)]);
            count_before[k] = wr_count[word_addr(base.base_c, k)];
        end
        total_before  = wr_total;
        done_before   = done_count;
        c_rd_before   = c_rd_total;
        c_rd_expected = (mode == PWO_PWM && acc) ? NUM_WORDS : 0;

        @(negedge clk);
        mode_i          = mode;
        accumulate_i    = acc;
        base_addr_i     = base;
        enable_i        = 1'b1;
        sampler_valid_i = draw_valid(gaps);
        @(negedge clk);
        enable_i = 1'b0;
        if (!busy_o) begin
            report_error("busy_o did not rise after enable_i");
        end

        // Mode, accumulate and base inputs wander while the DUT holds its own copy
        cycles = 0;
        while (!done_o && !(zero_after > 0 && wr_total - total_before >= zero_after)
               && cycles < TIMEOUT) begin
            sampler_valid_i = draw_valid(gaps);
            mode_i          = pwo_mode_t'(2'(next_rand() % 3));
            accumulate_i    = ~accumulate_i;
            base_addr_i     = 45'({next_rand(), next_rand()});
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            $display("Timeout: operation made no progress within %0d cycles", TIMEOUT);
            timeouts++;
            return;
        end

        if (zero_after > 0) begin
            zeroize_i = 1'b1;
            @(negedge clk);
            zeroize_i    = 1'b0;
            total_before = wr_total;
            for (int i = 0; i < 8; i++) begin
                if (busy_o || done_o || wr_req_o.rd_wr_en != RW_IDLE) begin
                    report_error("activity after zeroize_i");
                end
                @(negedge clk);
            end
            if (wr_total != total_before) begin
                report_error($sformatf("%0d writes after zeroize_i", wr_total - total_before));
            end
            return;
        end

        if (busy_o) begin
            report_error("busy_o still high while done_o is high");
        end
        @(negedge clk);
        if (done_o || done_count - done_before != 1) begin
            report_error("done_o is not a single pulse");
        end
        if (done_cycle != last_wr_cycle + 1) begin
            report_error($sformatf("done_o %0d cycles after the last write",
                                   done_cycle - last_wr_cycle));
        end
        if (busy_o) begin
            report_error("busy_o high after the operation");
        end
        if (c_rd_total - c_rd_before != c_rd_expected) begin
            report_error($sformatf("%0d c reads, expected %0d", c_rd_total - c_rd_before,
                                   c_rd_expected));
        end
        if (wr_total - total_before != NUM_WORDS) begin
            report_error($sformatf("%0d writes, expected %0d", wr_total - total_before,
                                   NUM_WORDS));
        end
        for (int k = 0; k < NUM_WORDS; k++) begin
            addr = word_addr(base.base_c, k);
            if (wr_count[addr] - count_before[k] != 1) begin
                report_error($sformatf("address %h written %0d times", addr,
                                       wr_count[addr] - count_before[k]));
            end
            if (result[addr] != expected[k]) begin
                report_error($sformatf("%s word %0d got %h expected %h", mode.name(), k,
                                       result[addr], expected[k]));
            end
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        rand_state      = SEED;
        errors          = 0;
        timeouts        = 0;
        reset_n         = 1'b0;
        zeroize_i       = 1'b0;
        enable_i        = 1'b0;
        mode_i          = PWO_PWM;
        accumulate_i    = 1'b0;
        sampler_valid_i = 1'b0;
        base_addr_i     = '0;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        if (busy_o || done_o || wr_req_o.rd_wr_en != RW_IDLE
            || a_rd_req_o.rd_wr_en != RW_IDLE || b_rd_req_o.rd_wr_en != RW_IDLE
            || c_rd_req_o.rd_wr_en != RW_IDLE) begin
            report_error("outputs not idle after reset");
        end

        run_op(PWO_PWM, 1'b0, 1'b0, 0);
        run_op(PWO_PWM, 1'b1, 1'b0, 0);
        run_op(PWO_PWA, 1'b0, 1'b0, 0);
        run_op(PWO_PWS, 1'b0, 1'b0, 0);
        // Sampler gaps stall the sequencer
        run_op(PWO_PWM, 1'b1, 1'b1, 0);
        // Stale c data on the read port must not leak into the product
        run_op(PWO_PWM, 1'b0, 1'b1, 0);
        run_op(PWO_PWA, 1'b0, 1'b1, 0);
        run_op(PWO_PWS, 1'b0, 1'b1, 0);
        // Zeroize mid-run and a clean operation after it
        run_op(PWO_PWS, 1'b0, 1'b1, 20);
        run_op(PWO_PWM, 1'b1, 1'b1, 0);

        $display("Errors: %0d, assertion failures: %0d, timeouts: %0d", errors,
                 u_pwo_top.u_assert.fail_count, timeouts);
        if (errors == 0 && timeouts == 0 && u_pwo_top.u_assert.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- test/pwo_top_assert.sv
// Concurrent assertions on the pointwise engine top level
// Request pairing, idle requests outside a run, done pulse, zeroize

module pwo_top_assert (
    input logic                      clk,
    input logic                      reset_n,
    input logic                      zeroize_i,
    input pwo_defines_pkg::mem_req_t a_rd_req_o,
    input pwo_defines_pkg::mem_req_t b_rd_req_o,
    input pwo_defines_pkg::mem_req_t c_rd_req_o,
    input pwo_defines_pkg::mem_req_t wr_req_o,
    input logic                      busy_o,
    input logic                      done_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import pwo_defines_pkg::*;

    logic reads_idle;
    logic writes_idle;
    int   fail_count = 0;

    assign reads_idle  = (a_rd_req_o.rd_wr_en == RW_IDLE) && (b_rd_req_o.rd_wr_en == RW_IDLE)
                         && (c_rd_req_o.rd_wr_en == RW_IDLE);
    assign writes_idle = (wr_req_o.rd_wr_en == RW_IDLE);

    a_b_paired: assert property (@(posedge clk) disable iff (!reset_n)
        a_rd_req_o.rd_wr_en == b_rd_req_o.rd_wr_en)
        else begin
            fail_count++;
            $error("a and b read requests differ");
        end

    reads_only_busy: assert property (@(posedge clk) disable iff (!reset_n)
        !busy_o |-> reads_idle)
        else begin
            fail_count++;
            $error("read request while not busy");
        end

    // A write may trail the end of busy by up to the pipeline depth
    writes_near_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (!busy_o && !writes_idle) |-> ($past(busy_o, 1) || $past(busy_o, 2)
        || $past(busy_o, 3) || $past(busy_o, 4) || $past(busy_o, 5)))
        else begin
            fail_count++;
            $error("write request long after busy fell");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o)
        else begin
            fail_count++;
            $error("done_o high for more than one cycle");
        end

    zeroize_idle: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (reads_idle && writes_idle && !busy_o && !done_o))
        else begin
            fail_count++;
            $error("requests active after zeroize");
        end

endmodule

bind pwo_top pwo_top_assert u_assert (
    .clk        (clk),
    .reset_n    (reset_n),
    .zeroize_i  (zeroize_i),
    .a_rd_req_o (a_rd_req_o),
    .b_rd_req_o (b_rd_req_o),
    .c_rd_req_o (c_rd_req_o),
    .wr_req_o   (wr_req_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
);

//--- src/pwo_top.sv
// Top level of the ML-DSA pointwise engine
// Sequencer and datapath with their connecting wires

module pwo_top #(
    parameter int NUM_WORDS = mldsa_params_pkg::MLDSA_N / mldsa_params_pkg::COEFFS_PER_WORD
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic                            enable_i,
    input  pwo_defines_pkg::pwo_mode_t      mode_i,
    input  logic                            accumulate_i,
    input  logic                            sampler_valid_i,
    input  pwo_defines_pkg::pwo_base_addr_t base_addr_i,
    input  mldsa_params_pkg::mem_word_t     a_rd_data_i,
    input  mldsa_params_pkg::mem_word_t     b_rd_data_i,
    input  mldsa_params_pkg::mem_word_t     c_rd_data_i,
    output pwo_defines_pkg::mem_req_t       a_rd_req_o,
    output pwo_defines_pkg::mem_req_t       b_rd_req_o,
    output pwo_defines_pkg::mem_req_t       c_rd_req_o,
    output pwo_defines_pkg::mem_req_t       wr_req_o,
    output mldsa_params_pkg::mem_word_t     wr_data_o,
    output logic                            busy_o,
    output logic                            done_o
);
    import mldsa_params_pkg::*;
    import pwo_defines_pkg::*;

    logic      issue;
    mem_addr_t idx;
    pwo_mode_t op_mode;
    logic      op_accumulate;
    mem_addr_t base_c;

    pwo_ctrl #(
        .NUM_WORDS (NUM_WORDS)
    ) u_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .enable_i        (enable_i),
        .mode_i          (mode_i),
        .accumulate_i    (accumulate_i),
        .sampler_valid_i (sampler_valid_i),
        .base_addr_i     (base_addr_i),
        .a_rd_req_o      (a_rd_req_o),
        .b_rd_req_o      (b_rd_req_o),
        .c_rd_req_o      (c_rd_req_o),
        .issue_o         (issue),
        .idx_o           (idx),
        .op_mode_o       (op_mode),
        .op_accumulate_o (op_accumulate),
        .base_c_o        (base_c),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    pwo_datapath u_datapath (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .issue_i         (issue),
        .idx_i           (idx),
        .op_mode_i       (op_mode),
        .op_accumulate_i (op_accumulate),
        .base_c_i        (base_c),
        .a_rd_data_i     (a_rd_data_i),
        .b_rd_data_i     (b_rd_data_i),
        .c_rd_data_i     (c_rd_data_i),
        .wr_req_o        (wr_req_o),
        .wr_data_o       (wr_data_o)
    );

endmodule

//--- src/pwo_datapath.sv
// Datapath of the pointwise engine
// Operand registers, four coefficient lanes
// Write request aligned with the lane results

module pwo_datapath (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize_i,
    input  logic                        issue_i,
    input  mldsa_params_pkg::mem_addr_t idx_i,
    input  pwo_defines_pkg::pwo_mode_t  op_mode_i,
    input  logic                        op_accumulate_i,
    input  mldsa_params_pkg::mem_addr_t base_c_i,
    input  mldsa_params_pkg::mem_word_t a_rd_data_i,
    input  mldsa_params_pkg::mem_word_t b_rd_data_i,
    input  mldsa_params_pkg::mem_word_t c_rd_data_i,
    output pwo_defines_pkg::mem_req_t   wr_req_o,
    output mldsa_params_pkg::mem_word_t wr_data_o
);
    import mldsa_params_pkg::*;
    import pwo_defines_pkg::*;

    // Valid and word index travelling with the data
    typedef struct packed {
        logic      vld;
        mem_addr_t idx;
    } pipe_tag_t;

    pipe_tag_t       tag_d1;
    pipe_tag_t [3:0] tag_sr;
    mem_word_t       a_q;
    mem_word_t       b_q;
    mem_word_t       c_q;
    coeff_t          lane_res [COEFFS_PER_WORD];

    // ============================================================
    // Operand capture one cycle after the memory answers
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_d1 <= '0;
            tag_sr <= '0;
            a_q    <= '0;
            b_q    <= '0;
            c_q    <= '0;
        end else if (zeroize_i) begin
            tag_d1 <= '0;
            tag_sr <= '0;
            a_q    <= '0;
            b_q    <= '0;
            c_q    <= '0;
        end else begin
            tag_d1 <= '{vld: issue_i, idx: idx_i};
            tag_sr <= {tag_sr[2:0], tag_d1};
            if (tag_d1.vld) begin
                a_q <= a_rd_data_i;
                b_q <= b_rd_data_i;
                // No c read without accumulate
                c_q <= op_accumulate_i ? c_rd_data_i : '0;
            end
        end
    end

    // ============================================================
    // Lanes
    // ============================================================
    for (genvar g = 0; g < COEFFS_PER_WORD; g++) begin : g_lane
        pwo_lane u_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .op_mode_i (op_mode_i),
            .a_i       (a_q[g*LANE_WIDTH +: COEFF_WIDTH]),
            .b_i       (b_q[g*LANE_WIDTH +: COEFF_WIDTH]),
            .c_i       (c_q[g*LANE_WIDTH +: COEFF_WIDTH]),
            .res_o     (lane_res[g])
        );
    end

    // Top bit of every slot written as zero
    always_comb begin
        wr_data_o = '0;
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            wr_data_o[i*LANE_WIDTH +: LANE_WIDTH] = {1'b0, lane_res[i]};
        end
    end

    assign wr_req_o.rd_wr_en = tag_sr[3].vld ? RW_WRITE : RW_IDLE;
    assign wr_req_o.addr     = tag_sr[3].vld ? base_c_i + tag_sr[3].idx : '0;

endmodule

//--- src/pwo_lane.sv
// One coefficient lane of the pointwise engine
// Multiply with accumulate, add and subtract modulo Q
// Three-cycle latency in every mode

module pwo_lane (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize_i,
    input  pwo_defines_pkg::pwo_mode_t op_mode_i,
    input  mldsa_params_pkg::coeff_t   a_i,
    input  mldsa_params_pkg::coeff_t   b_i,
    input  mldsa_params_pkg::coeff_t   c_i,
    output mldsa_params_pkg::coeff_t   res_o
);
    import mldsa_params_pkg::*;
    import pwo_defines_pkg::*;

    logic [23:0] sum_w;
    logic [23:0] diff_w;
    logic [23:0] acc_w;
    coeff_t      addsub;
    coeff_t      acc_red;
    coeff_t      prod;
    coeff_t      as_s1;
    coeff_t      as_s2;
    coeff_t      c_s1;
    coeff_t      c_s2;

    pwo_mod_mul u_mul (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .prod_o    (prod)
    );

    always_comb begin
        sum_w  = {1'b0, a_i} + {1'b0, b_i};
        diff_w = {1'b0, a_i} - {1'b0, b_i};
        if (op_mode_i == PWO_PWS) begin
            // Borrow means a negative difference, fold back by Q
            addsub = (a_i < b_i) ? coeff_t'(diff_w + {1'b0, MLDSA_Q}) : coeff_t'(diff_w);
        end else begin
            addsub = (sum_w >= {1'b0, MLDSA_Q}) ? coeff_t'(sum_w - {1'b0, MLDSA_Q})
                                               : coeff_t'(sum_w);
        end
        // Accumulate term meets the product in stage three
        acc_w   = {1'b0, prod} + {1'b0, c_s2};
        acc_red = (acc_w >= {1'b0, MLDSA_Q}) ? coeff_t'(acc_w - {1'b0, MLDSA_Q})
                                            : coeff_t'(acc_w);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            as_s1 <= '0;
            as_s2 <= '0;
            c_s1  <= '0;
            c_s2  <= '0;
            res_o <= '0;
        end else if (zeroize_i) begin
            as_s1 <= '0;
            as_s2 <= '0;
            c_s1  <= '0;
            c_s2  <= '0;
            res_o <= '0;
        end else begin
            as_s1 <= addsub;
            as_s2 <= as_s1;
            c_s1  <= c_i;
            c_s2  <= c_s1;
            res_o <= (op_mode_i == PWO_PWM) ? acc_red : as_s2;
        end
    end

endmodule

//--- src/pwo_mod_mul.sv
// Two-stage modular multiplier modulo Q
// Full product in stage one, Barrett reduction in stage two

module pwo_mod_mul (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize_i,
    input  mldsa_params_pkg::coeff_t a_i,
    input  mldsa_params_pkg::coeff_t b_i,
    output mldsa_params_pkg::coeff_t prod_o
);
    import mldsa_params_pkg::*;

    localparam int PROD_WIDTH = 2 * COEFF_WIDTH;

    // floor(2^46 / Q)
    localparam logic [23:0] BARRETT_MU = 24'd8396807;

    logic [PROD_WIDTH-1:0] prod_q;
    logic [69:0]           prod_mu;
    logic [23:0]           q_est;
    logic [46:0]           q_mod;
    logic [23:0]           rem;
    coeff_t                rem_red;

    // Estimate is low by at most one, so the remainder stays below 2Q
    always_comb begin
        prod_mu = prod_q * BARRETT_MU;
        q_est   = prod_mu[69:46];
        q_mod   = q_est * MLDSA_Q;
        rem     = 24'({1'b0, prod_q} - q_mod);
        if (rem >= {1'b0, MLDSA_Q}) begin
            rem_red = coeff_t'(rem - {1'b0, MLDSA_Q});
        end else begin
            rem_red = coeff_t'(rem);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            prod_o <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            prod_o <= '0;
        end else begin
            prod_q <= a_i * b_i;
            prod_o <= rem_red;
        end
    end

endmodule

//--- src/pwo_ctrl.sv
// Sequencer of the pointwise engine
// Walks the word index and issues the a, b and c read requests
// Holds busy and raises the done pulse after the pipeline drains

module pwo_ctrl #(
    parameter int NUM_WORDS = 64
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic                            enable_i,
    input  pwo_defines_pkg::pwo_mode_t      mode_i,
    input  logic                            accumulate_i,
    input  logic                            sampler_valid_i,
    input  pwo_defines_pkg::pwo_base_addr_t base_addr_i,
    output pwo_defines_pkg::mem_req_t       a_rd_req_o,
    output pwo_defines_pkg::mem_req_t       b_rd_req_o,
    output pwo_defines_pkg::mem_req_t       c_rd_req_o,
    output logic                            issue_o,
    output mldsa_params_pkg::mem_addr_t     idx_o,
    output pwo_defines_pkg::pwo_mode_t      op_mode_o,
    output logic                            op_accumulate_o,
    output mldsa_params_pkg::mem_addr_t     base_c_o,
    output logic                            busy_o,
    output logic                            done_o
);
    import mldsa_params_pkg::*;
    import pwo_defines_pkg::*;

    // Memory, operand register and three lane stages
    localparam int DRAIN_CYCLES = 5;

    pwo_state_t     state_q;
    mem_addr_t      k_q;
    logic [2:0]     drain_q;
    pwo_mode_t      mode_q;
    logic           acc_q;
    pwo_base_addr_t base_q;

    logic issue;
    logic last_word;
    logic c_read;

    // A request goes out only while the sampler holds valid high
    assign issue     = (state_q == ST_RUN) && sampler_valid_i;
    assign last_word = (k_q == mem_addr_t'(NUM_WORDS - 1));
    assign c_read    = issue && (mode_q == PWO_PWM) && acc_q;

    // ============================================================
    // FSM and counters
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ST_IDLE;
            k_q     <= '0;
            drain_q <= '0;
            mode_q  <= PWO_PWM;
            acc_q   <= 1'b0;
            base_q  <= '0;
        end else if (zeroize_i) begin
            state_q <= ST_IDLE;
            k_q     <= '0;
            drain_q <= '0;
            mode_q  <= PWO_PWM;
            acc_q   <= 1'b0;
            base_q  <= '0;
        end else begin
            unique case (state_q)
                ST_IDLE: begin
                    if (enable_i) begin
                        mode_q  <= mode_i;
                        acc_q   <= accumulate_i;
                        base_q  <= base_addr_i;
                        k_q     <= '0;
                        state_q <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (issue) begin
                        if (last_word) begin
                            drain_q <= '0;
                            state_q <= ST_DRAIN;
                        end else begin
                            k_q <= k_q + 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (drain_q == 3'(DRAIN_CYCLES - 1)) begin
                        state_q <= ST_DONE;
                    end else begin
                        drain_q <= drain_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Read request address is base plus word index
    assign a_rd_req_o.rd_wr_en = issue ? RW_READ : RW_IDLE;
    assign a_rd_req_o.addr     = issue ? base_q.base_a + k_q : '0;
    assign b_rd_req_o.rd_wr_en = issue ? RW_READ : RW_IDLE;
    assign b_rd_req_o.addr     = issue ? base_q.base_b + k_q : '0;
    assign c_rd_req_o.rd_wr_en = c_read ? RW_READ : RW_IDLE;
    assign c_rd_req_o.addr     = c_read ? base_q.base_c + k_q : '0;

    assign issue_o         = issue;
    assign idx_o           = k_q;
    assign op_mode_o       = mode_q;
    assign op_accumulate_o = acc_q;
    assign base_c_o        = base_q.base_c;

    assign busy_o = (state_q == ST_RUN) || (state_q == ST_DRAIN);
    assign done_o = (state_q == ST_DONE);

endmodule

//--- src/pwo_defines_pkg.sv
// Pointwise engine definitions
// Operation mode, memory request and sequencer state enums
// Memory request and base address structs

package pwo_defines_pkg;

    typedef enum logic [1:0] {
        PWO_PWM = 2'd0,
        PWO_PWA = 2'd1,
        PWO_PWS = 2'd2
    } pwo_mode_t;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } rw_t;

    // Request toward one memory
    typedef struct packed {
        rw_t                         rd_wr_en;
        mldsa_params_pkg::mem_addr_t addr;
    } mem_req_t;

    // Polynomial base addresses for a, b and the destination c
    typedef struct packed {
        mldsa_params_pkg::mem_addr_t base_a;
        mldsa_params_pkg::mem_addr_t base_b;
        mldsa_params_pkg::mem_addr_t base_c;
    } pwo_base_addr_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2,
        ST_DONE  = 2'd3
    } pwo_state_t;

endpackage

//--- src/mldsa_params_pkg.sv
// ML-DSA arithmetic constants
// Memory word geometry for packed coefficients
// Vector types for coefficients, memory words and addresses

package mldsa_params_pkg;

    // Modulus and coefficient width
    localparam int COEFF_WIDTH = 23;
    localparam logic [COEFF_WIDTH-1:0] MLDSA_Q = 23'd8380417;

    // One polynomial
    localparam int MLDSA_N = 256;

    // Four coefficients per word, each in a 24-bit slot
    localparam int LANE_WIDTH      = 24;
    localparam int COEFFS_PER_WORD = 4;
    localparam int MEM_DATA_WIDTH  = COEFFS_PER_WORD * LANE_WIDTH;
    localparam int MEM_ADDR_WIDTH  = 15;

    typedef logic [COEFF_WIDTH-1:0]    coeff_t;
    typedef logic [MEM_DATA_WIDTH-1:0] mem_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

endpackage
